// File: verilog.f
qp_types_pkg.sv
roce_proto_pkg.sv
qp_cmd_fsm.sv
qp_psn_calc.sv
qp_context_table.sv
qp_state_top.sv
qp_state_assertions.sv
qp_state_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the testbench with Verilator, then scan the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps -f verilog.f \
  --top-module qp_state_tb -o qp_state_sim > build.log 2>&1 \
  || { echo "Build failed, see build.log"; exit 1; }

./obj_dir/qp_state_sim > sim.log 2>&1

grep -q "Test failed" sim.log && { echo "Simulation FAILED, see sim.log"; exit 1; }
grep -q "Test passed" sim.log || { echo "Simulation ended without passing, see sim.log"; exit 1; }
echo "Simulation PASSED"

// File: qp_state_tb.sv
`default_nettype none

module qp_state_tb
  import qp_types_pkg::*, roce_proto_pkg::*;
;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int EV_OPEN  = 0;
  localparam int EV_RESET = 1;
  localparam int EV_ERROR = 2;
  localparam int EV_PSN   = 3;

  // Cycles per test with 2 per event and at most 3 to drain reads
  localparam int EV = 2;
  localparam int DR = 3;
  localparam int SCHED_CYCLES = 3 + (4 * EV + 4 + DR) + (EV + 1 + DR) +
                                5 * (1 + 4 * (EV + 1 + DR)) + (6 * EV + 5 + 2 * DR) +
                                (4 * EV + 3 * (1 + DR)) + (12 + 2 * DR + 4 * EV) + 2;
  localparam int TIMEOUT_CYCLES = SCHED_CYCLES + 50;

  logic        clk;
  logic        rst_qp;
  logic        qp_init_valid;
  logic        qp_init_open;
  qp_init_t    qp_init;
  logic        qp_close_valid;
  qpn_t        qp_close_qpn;
  logic        rx_ack_valid;
  rx_ack_t     rx_ack;
  logic        meta_valid;
  dma_meta_t   meta;
  logic        req_valid;
  qpn_t        req_qpn;
  pmtu_e       pmtu;
  logic        req_context_valid;
  logic        req_invalid;
  qp_context_t req_context;
  logic        open_failed;

  qp_context_t model [NUM_QP];
  int          cycles = 0;
  int          exp_due [$];
  logic        exp_bad [$];
  qp_context_t exp_ctx [$];

  qp_state_top qp_state_top_inst (
    .clk               (clk),
    .rst_qp            (rst_qp),
    .qp_init_valid     (qp_init_valid),
    .qp_init_open      (qp_init_open),
    .qp_init           (qp_init),
    .qp_close_valid    (qp_close_valid),
    .qp_close_qpn      (qp_close_qpn),
    .rx_ack_valid      (rx_ack_valid),
    .rx_ack            (rx_ack),
    .meta_valid        (meta_valid),
    .meta              (meta),
    .req_valid         (req_valid),
    .req_qpn           (req_qpn),
    .pmtu              (pmtu),
    .req_context_valid (req_context_valid),
    .req_invalid       (req_invalid),
    .req_context       (req_context),
    .open_failed       (open_failed)
  );

  bind qp_state_top qp_state_assertions qp_state_assertions_inst (
    .clk               (clk),
    .rst_qp            (rst_qp),
    .wr_en             (wr_en),
    .req_context_valid (req_context_valid),
    .req_invalid       (req_invalid),
    .open_failed       (open_failed)
  );

  initial clk = 1'b0;
  always #50 clk = ~clk;

  task automatic fail_now(input string msg);
    $display("%s", msg);
    $display("Test failed");
    $fatal(1, "stopped at the first error");
  endtask

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      fail_now("Timeout, the run did not finish within the cycle limit");
    end
  end

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      fail_now($sformatf("FAILED %s got %h expected %h", name, got, exp));
    end
  endtask

  task automatic check_psn(input string name, input psn_t got, input psn_t exp);
    if (got !== exp) begin
      fail_now($sformatf("FAILED %s got %h expected %h", name, got, exp));
    end
  endtask

  task automatic check_context(input qp_context_t got, input qp_context_t exp);
    if (got !== exp) begin
      fail_now($sformatf("FAILED req_context got %h expected %h", got, exp));
    end
  endtask

  function automatic logic qpn_valid(input qpn_t qpn);
    int q;
    q = int'(qpn);
    return (q >= 256) && (q < 256 + NUM_QP);
  endfunction

  // Remote PSN after ceil(len / MTU) packets
  function automatic psn_t ref_psn(input psn_t base, input dma_len_t len, input pmtu_e sel);
    logic [63:0] mtu;
    logic [63:0] pkts;
    mtu  = 64'd1 << (8 + int'(sel));
    pkts = (64'(len) + mtu - 64'd1) / mtu;
    return base + pkts[23:0];
  endfunction

  function automatic qp_context_t ref_update(input qp_context_t cur, input int kind,
                                             input qp_init_t init, input psn_t psn,
                                             input syndrome_t syn);
    qp_context_t nxt;
    nxt = cur;
    case (kind)
      EV_OPEN: begin
        if (cur.state == RESET) begin
          nxt.state       = RTS;
          nxt.syndrome    = 8'h00;
          nxt.rem_ip_addr = init.rem_ip_addr;
          nxt.rem_qpn     = init.rem_qpn;
          nxt.loc_qpn     = init.loc_qpn;
          nxt.rem_psn     = init.rem_psn;
          nxt.loc_psn     = init.loc_psn;
          nxt.rem_addr    = init.rem_addr;
          nxt.r_key       = init.r_key;
        end
      end
      EV_PSN: begin
        nxt.rem_psn  = psn;
        nxt.syndrome = 8'h00;
      end
      EV_ERROR: begin
        nxt.state    = ERROR;
        nxt.syndrome = syn;
      end
      default: begin
        nxt.state    = RESET;
        nxt.syndrome = 8'h00;
      end
    endcase
    return nxt;
  endfunction

  function automatic qp_init_t rand_init(input qpn_t qpn);
    qp_init_t r;
    r.rem_ip_addr = $urandom;
    r.rem_qpn     = qpn_t'($urandom);
    r.loc_qpn     = qpn;
    r.rem_psn     = psn_t'($urandom);
    r.loc_psn     = psn_t'($urandom);
    r.rem_addr    = {$urandom, $urandom};
    r.r_key       = $urandom;
    return r;
  endfunction

  // Ends the event pulse, checks open_failed at the write edge, updates the model
  task automatic finish_event(input logic takes, input int kind, input qpn_t qpn,
                              input qp_init_t init, input psn_t psn, input syndrome_t syn);
    logic hit;
    logic exp_fail;
    int   idx;
    hit      = takes && qpn_valid(qpn);
    idx      = hit ? int'(qpn) - 256 : 0;
    exp_fail = hit && (kind == EV_OPEN) && (model[idx].state != RESET);
    @(negedge clk);
    qp_init_valid  = 1'b0;
    qp_close_valid = 1'b0;
    rx_ack_valid   = 1'b0;
    meta_valid     = 1'b0;
    @(negedge clk);
    check_flag("open_failed", open_failed, exp_fail);
    if (hit) begin
      model[idx] = ref_update(model[idx], kind, init, psn, syn);
    end
  endtask

  task automatic send_init(input logic open, input qp_init_t init);
    qp_init_valid = 1'b1;
    qp_init_open  = open;
    qp_init       = init;
    finish_event(1'b1, open ? EV_OPEN : EV_RESET, init.loc_qpn, init, '0, '0);
  endtask

  task automatic send_close(input qpn_t qpn);
    qp_close_valid = 1'b1;
    qp_close_qpn   = qpn;
    finish_event(1'b1, EV_ERROR, qpn, '0, '0, 8'h9F);
  endtask

  task automatic send_ack(input logic [7:0] op, input qpn_t qpn, input syndrome_t syn);
    logic fatal;
    fatal           = (op == 8'h11) && (syn[6:5] == 2'b11) && (syn[4:0] != 5'd0);
    rx_ack_valid    = 1'b1;
    rx_ack.op_code  = op;
    rx_ack.psn      = psn_t'($urandom);
    rx_ack.dest_qp  = qpn;
    rx_ack.syndrome = syn;
    finish_event(fatal, EV_ERROR, qpn, '0, '0, syn);
  endtask

  task automatic send_meta(input qpn_t qpn, input psn_t psn, input dma_len_t len);
    psn_t exp;
    exp             = ref_psn(psn, len, pmtu);
    meta_valid      = 1'b1;
    meta.dma_length = len;
    meta.loc_qpn    = qpn;
    meta.rem_psn    = psn;
    finish_event(1'b1, EV_PSN, qpn, '0, exp, '0);
  endtask

  task automatic issue_read(input qpn_t qpn);
    req_valid = 1'b1;
    req_qpn   = qpn;
    exp_due.push_back(cycles + 2);
    exp_bad.push_back(!qpn_valid(qpn));
    exp_ctx.push_back(qpn_valid(qpn) ? model[int'(qpn) - 256] : '0);
    @(negedge clk);
    req_valid = 1'b0;
  endtask

  task automatic wait_reads();
    while (exp_due.size() > 0) begin
      @(negedge clk);
    end
  endtask

  task automatic read_all();
    for (int i = 0; i < NUM_QP; i++) begin
      issue_read(qpn_t'(256 + i));
    end
    wait_reads();
  endtask

  // Compare process for the read port
  always @(negedge clk) begin
    if (!rst_qp) begin
      if (exp_due.size() > 0 && exp_due[0] == cycles) begin
        check_flag("req_context_valid", req_context_valid, !exp_bad[0]);
        check_flag("req_invalid", req_invalid, exp_bad[0]);
        if (!exp_bad[0]) begin
          check_psn("req_context.rem_psn", req_context.rem_psn, exp_ctx[0].rem_psn);
          check_context(req_context, exp_ctx[0]);
        end
        void'(exp_due.pop_front());
        void'(exp_bad.pop_front());
        void'(exp_ctx.pop_front());
      end else begin
        check_flag("req_context_valid", req_context_valid, 1'b0);
        check_flag("req_invalid", req_invalid, 1'b0);
      end
    end
  end

  initial begin
    dma_len_t len;
    void'($urandom(32'h68813f71));
    rst_qp         = 1'b1;
    qp_init_valid  = 1'b0;
    qp_init_open   = 1'b0;
    qp_init        = '0;
    qp_close_valid = 1'b0;
    qp_close_qpn   = '0;
    rx_ack_valid   = 1'b0;
    rx_ack         = '0;
    meta_valid     = 1'b0;
    meta           = '0;
    req_valid      = 1'b0;
    req_qpn        = '0;
    pmtu           = MTU_256;
    for (int i = 0; i < NUM_QP; i++) begin
      model[i] = '0;
    end
    repeat (2) @(negedge clk);
    rst_qp = 1'b0;
    @(negedge clk);
    check_flag("open_failed", open_failed, 1'b0);

    // Open every QP and read back
    for (int i = 0; i < NUM_QP; i++) begin
      send_init(1'b1, rand_init(qpn_t'(256 + i)));
    end
    read_all();

    // Second open of an RTS QP
    send_init(1'b1, rand_init(qpn_t'(256)));
    issue_read(qpn_t'(256));
    wait_reads();

    // PSN advance at every path MTU
    for (int m = 0; m <= 4; m++) begin
      pmtu = pmtu_e'(3'(m));
      @(negedge clk);
      send_meta(qpn_t'(256 + m % NUM_QP), psn_t'($urandom), $urandom);
      issue_read(qpn_t'(256 + m % NUM_QP));
      wait_reads();
      len = dma_len_t'($urandom_range(1, 64)) << (8 + m);
      send_meta(qpn_t'(257), psn_t'($urandom), len);
      issue_read(qpn_t'(257));
      wait_reads();
      len = (dma_len_t'(40) << (8 + m)) - dma_len_t'(3);
      send_meta(qpn_t'(258), 24'hFFFFF0, len);
      issue_read(qpn_t'(258));
      wait_reads();
      send_meta(qpn_t'(259), psn_t'($urandom), dma_len_t'($urandom_range(1, 20000)));
      issue_read(qpn_t'(259));
      wait_reads();
    end

    // ACKs and NAKs that must not change anything
    send_ack(8'h11, qpn_t'(257), 8'h00);
    send_ack(8'h11, qpn_t'(257), 8'h60);
    send_ack(8'h11, qpn_t'(257), 8'h1F);
    send_ack(8'h0D, qpn_t'(257), 8'h63);
    issue_read(qpn_t'(257));
    wait_reads();

    // Fatal NAK and close
    send_ack(8'h11, qpn_t'(257), syndrome_t'({3'b011, 5'($urandom_range(1, 31))}));
    send_close(qpn_t'(258));
    read_all();

    // Back to RESET, then a fresh open
    send_init(1'b0, rand_init(qpn_t'(257)));
    issue_read(qpn_t'(257));
    wait_reads();
    send_init(1'b1, rand_init(qpn_t'(257)));
    issue_read(qpn_t'(257));
    wait_reads();
    send_init(1'b0, rand_init(qpn_t'(258)));
    send_init(1'b1, rand_init(qpn_t'(258)));
    issue_read(qpn_t'(258));
    wait_reads();

    // Out-of-range QPNs mixed with back-to-back valid reads
    issue_read(qpn_t'(255));
    issue_read(qpn_t'(256));
    issue_read(qpn_t'(260));
    issue_read(qpn_t'(257));
    issue_read(qpn_t'(0));
    issue_read(qpn_t'(259));
    issue_read(24'hFFFFFF);
    issue_read(qpn_t'(258));
    wait_reads();
    send_init(1'b1, rand_init(qpn_t'(255)));
    send_close(qpn_t'(260));
    send_ack(8'h11, qpn_t'(0), 8'h65);
    send_meta(qpn_t'(300), psn_t'($urandom), $urandom);
    read_all();

    repeat (2) @(negedge clk);
    $display("Test passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: qp_state_assertions.sv
`default_nettype none

module qp_state_assertions (
  input logic clk,
  input logic rst_qp,
  input logic wr_en,
  input logic req_context_valid,
  input logic req_invalid,
  input logic open_failed
);
  timeunit 1ns;
  timeprecision 1ps;

  // One write per accepted event
  wr_en_single: assert property (
    @(posedge clk) disable iff (rst_qp) wr_en |=> !wr_en
  ) else $error("wr_en was high for two cycles in a row");

  read_result_onehot: assert property (
    @(posedge clk) disable iff (rst_qp) !(req_context_valid && req_invalid)
  ) else $error("req_context_valid and req_invalid were high together");

  // open_failed is registered at the table write edge
  open_failed_after_write: assert property (
    @(posedge clk) disable iff (rst_qp) open_failed |-> $past(wr_en)
  ) else $error("open_failed was high without a write in the cycle before");

endmodule

`default_nettype wire

// File: qp_state_top.sv
`default_nettype none

module qp_state_top
  import qp_types_pkg::*, roce_proto_pkg::*;
(
  input  logic        clk,
  input  logic        rst_qp,
  input  logic        qp_init_valid,
  input  logic        qp_init_open,
  input  qp_init_t    qp_init,
  input  logic        qp_close_valid,
  input  qpn_t        qp_close_qpn,
  input  logic        rx_ack_valid,
  input  rx_ack_t     rx_ack,
  input  logic        meta_valid,
  input  dma_meta_t   meta,
  input  logic        req_valid,
  input  qpn_t        req_qpn,
  input  pmtu_e       pmtu,
  output logic        req_context_valid,
  output logic        req_invalid,
  output qp_context_t req_context,
  output logic        open_failed
);

  dma_meta_t meta_latched;
  psn_t      next_psn;
  logic      wr_en;
  wr_op_e    wr_op;
  qp_idx_t   wr_idx;
  qp_init_t  wr_init;
  psn_t      wr_psn;
  syndrome_t wr_syndrome;

  qp_cmd_fsm qp_cmd_fsm_inst (
    .clk            (clk),
    .rst_qp         (rst_qp),
    .qp_init_valid  (qp_init_valid),
    .qp_init_open   (qp_init_open),
    .qp_init        (qp_init),
    .qp_close_valid (qp_close_valid),
    .qp_close_qpn   (qp_close_qpn),
    .rx_ack_valid   (rx_ack_valid),
    .rx_ack         (rx_ack),
    .meta_valid     (meta_valid),
    .meta           (meta),
    .next_psn       (next_psn),
    .meta_latched   (meta_latched),
    .wr_en          (wr_en),
    .wr_op          (wr_op),
    .wr_idx         (wr_idx),
    .wr_init        (wr_init),
    .wr_psn         (wr_psn),
    .wr_syndrome    (wr_syndrome)
  );

  // Works on the latched metadata, off the event decode path
  qp_psn_calc qp_psn_calc_inst (
    .clk      (clk),
    .rst_qp   (rst_qp),
    .pmtu     (pmtu),
    .meta     (meta_latched),
    .next_psn (next_psn)
  );

  qp_context_table qp_context_table_inst (
    .clk               (clk),
    .rst_qp            (rst_qp),
    .wr_en             (wr_en),
    .wr_op             (wr_op),
    .wr_idx            (wr_idx),
    .wr_init           (wr_init),
    .wr_psn            (wr_psn),
    .wr_syndrome       (wr_syndrome),
    .req_valid         (req_valid),
    .req_qpn           (req_qpn),
    .req_context_valid (req_context_valid),
    .req_invalid       (req_invalid),
    .req_context       (req_context),
    .open_failed       (open_failed)
  );

endmodule

`default_nettype wire

// File: qp_context_table.sv
`default_nettype none

module qp_context_table
  import qp_types_pkg::*, roce_proto_pkg::*;
(
  input  logic        clk,
  input  logic        rst_qp,
  input  logic        wr_en,
  input  wr_op_e      wr_op,
  input  qp_idx_t     wr_idx,
  input  qp_init_t    wr_init,
  input  psn_t        wr_psn,
  input  syndrome_t   wr_syndrome,
  input  logic        req_valid,
  input  qpn_t        req_qpn,
  output logic        req_context_valid,
  output logic        req_invalid,
  output qp_context_t req_context,
  output logic        open_failed
);

  qp_context_t ctx [NUM_QP];

  logic        rd_ok;
  logic        rd_valid_q1;
  logic        rd_bad_q1;
  qp_context_t rd_ctx_q1;
  logic        rd_valid_q2;
  logic        rd_bad_q2;
  qp_context_t rd_ctx_q2;

  always_ff @(posedge clk) begin
    if (rst_qp) begin
      for (int i = 0; i < NUM_QP; i++) begin
        ctx[i] <= '0;
      end
      open_failed <= 1'b0;
    end else begin
      open_failed <= 1'b0;
      if (wr_en) begin
        case (wr_op)
          OPEN: begin
            // Only a QP in RESET can be opened
            if (ctx[wr_idx].state == RESET) begin
              ctx[wr_idx] <= '{state:       RTS,
                               syndrome:    '0,
                               rem_ip_addr: wr_init.rem_ip_addr,
                               rem_qpn:     wr_init.rem_qpn,
                               loc_qpn:     wr_init.loc_qpn,
                               rem_psn:     wr_init.rem_psn,
                               loc_psn:     wr_init.loc_psn,
                               rem_addr:    wr_init.rem_addr,
                               r_key:       wr_init.r_key};
            end else begin
              open_failed <= 1'b1;
            end
          end
          SET_PSN: begin
            ctx[wr_idx].rem_psn  <= wr_psn;
            ctx[wr_idx].syndrome <= '0;
          end
          SET_ERROR: begin
            ctx[wr_idx].state    <= ERROR;
            ctx[wr_idx].syndrome <= wr_syndrome;
          end
          default: begin
            ctx[wr_idx].state    <= RESET;
            ctx[wr_idx].syndrome <= '0;
          end
        endcase
      end
    end
  end

  assign rd_ok = req_valid && qpn_in_range(req_qpn);

  // Read pipeline, stage 1 sees the context from before a same-cycle write
  always_ff @(posedge clk) begin
    if (rst_qp) begin
      rd_valid_q1 <= 1'b0;
      rd_bad_q1   <= 1'b0;
      rd_valid_q2 <= 1'b0;
      rd_bad_q2   <= 1'b0;
    end else begin
      rd_valid_q1 <= rd_ok;
      rd_bad_q1   <= req_valid && !rd_ok;
      rd_valid_q2 <= rd_valid_q1;
      rd_bad_q2   <= rd_bad_q1;
    end
  end

  always_ff @(posedge clk) begin
    rd_ctx_q1 <= ctx[qpn_to_idx(req_qpn)];
    rd_ctx_q2 <= rd_ctx_q1;
  end

  assign req_context_valid = rd_valid_q2;
  assign req_invalid       = rd_bad_q2;
  assign req_context       = rd_ctx_q2;

endmodule

`default_nettype wire

// File: qp_psn_calc.sv
`default_nettype none

module qp_psn_calc
  import qp_types_pkg::*, roce_proto_pkg::*;
(
  input  logic      clk,
  input  logic      rst_qp,
  input  pmtu_e     pmtu,
  input  dma_meta_t meta,
  output psn_t      next_psn
);

  logic [3:0] pmtu_shift;
  dma_len_t   len_mask;
  dma_len_t   pkt_whole;
  logic       len_partial;

  // Shift amount is log2 of the path MTU
  always_ff @(posedge clk) begin
    if (rst_qp) begin
      pmtu_shift <= 4'(PMTU_SHIFT_BASE);
    end else begin
      pmtu_shift <= 4'(PMTU_SHIFT_BASE) + 4'(pmtu);
    end
  end

  always_comb begin
    len_mask    = (dma_len_t'(1) << pmtu_shift) - dma_len_t'(1);
    pkt_whole   = meta.dma_length >> pmtu_shift;
    // A partial last packet still takes a PSN
    len_partial = |(meta.dma_length & len_mask);
    next_psn    = meta.rem_psn + psn_t'(pkt_whole) + psn_t'(len_partial);
  end

endmodule

`default_nettype wire

// File: qp_cmd_fsm.sv
`default_nettype none

module qp_cmd_fsm
  import qp_types_pkg::*, roce_proto_pkg::*;
(
  input  logic      clk,
  input  logic      rst_qp,
  input  logic      qp_init_valid,
  input  logic      qp_init_open,
  input  qp_init_t  qp_init,
  input  logic      qp_close_valid,
  input  qpn_t      qp_close_qpn,
  input  logic      rx_ack_valid,
  input  rx_ack_t   rx_ack,
  input  logic      meta_valid,
  input  dma_meta_t meta,
  input  psn_t      next_psn,
  output dma_meta_t meta_latched,
  output logic      wr_en,
  output wr_op_e    wr_op,
  output qp_idx_t   wr_idx,
  output qp_init_t  wr_init,
  output psn_t      wr_psn,
  output syndrome_t wr_syndrome
);

  typedef enum logic {
    IDLE,
    ACT
  } fsm_state_e;

  fsm_state_e state;

  logic      nak_fatal;
  logic      ev_take;
  logic      ev_go;
  qpn_t      ev_qpn;
  wr_op_e    ev_op;
  syndrome_t ev_syndrome;

  wr_op_e    op_q;
  qp_idx_t   idx_q;
  syndrome_t syndrome_q;
  qp_init_t  init_q;
  dma_meta_t meta_q;

  // NAK type with a nonzero code, PSN sequence errors excluded
  always_comb begin
    nak_fatal = rx_ack_valid && (rx_ack.op_code == RC_RDMA_ACK) &&
                (rx_ack.syndrome[SYN_TYPE_MSB:SYN_TYPE_LSB] == SYN_TYPE_NAK) &&
                (|rx_ack.syndrome[SYN_VAL_MSB:0]);
  end

  // Close, then fatal NAK, then metadata, then init
  always_comb begin
    ev_take     = 1'b0;
    ev_qpn      = qp_init.loc_qpn;
    ev_op       = SET_RESET;
    ev_syndrome = '0;
    if (qp_close_valid) begin
      ev_take     = 1'b1;
      ev_qpn      = qp_close_qpn;
      ev_op       = SET_ERROR;
      ev_syndrome = SYN_LOCAL_CLOSE;
    end else if (nak_fatal) begin
      ev_take     = 1'b1;
      ev_qpn      = rx_ack.dest_qp;
      ev_op       = SET_ERROR;
      ev_syndrome = rx_ack.syndrome;
    end else if (meta_valid) begin
      ev_take = 1'b1;
      ev_qpn  = meta.loc_qpn;
      ev_op   = SET_PSN;
    end else if (qp_init_valid) begin
      ev_take = 1'b1;
      ev_qpn  = qp_init.loc_qpn;
      ev_op   = qp_init_open ? OPEN : SET_RESET;
    end
    ev_go = ev_take && qpn_in_range(ev_qpn);
  end

  always_ff @(posedge clk) begin
    if (rst_qp) begin
      state <= IDLE;
    end else begin
      case (state)
        IDLE: begin
          if (ev_go) begin
            state <= ACT;
          end
        end
        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

  // Event payload held for the single write cycle
  always_ff @(posedge clk) begin
    if (state == IDLE && ev_go) begin
      op_q       <= ev_op;
      idx_q      <= qpn_to_idx(ev_qpn);
      syndrome_q <= ev_syndrome;
      init_q     <= qp_init;
      meta_q     <= meta;
    end
  end

  // next_psn comes back from the PSN calculator one cycle after the latch
  assign meta_latched = meta_q;
  assign wr_en        = (state == ACT);
  assign wr_op        = op_q;
  assign wr_idx       = idx_q;
  assign wr_init      = init_q;
  assign wr_psn       = next_psn;
  assign wr_syndrome  = syndrome_q;

endmodule

`default_nettype wire

// File: roce_proto_pkg.sv
`default_nettype none

package roce_proto_pkg;

  import qp_types_pkg::*;

  localparam logic [7:0] RC_RDMA_ACK = 8'h11;

  // First local QPN
  localparam qpn_t QPN_BASE = 24'd256;

  // AETH syndrome layout, type in [6:5] and value in [4:0]
  localparam int SYN_TYPE_MSB = 6;
  localparam int SYN_TYPE_LSB = 5;
  localparam int SYN_VAL_MSB  = 4;

  localparam logic [1:0] SYN_TYPE_NAK    = 2'b11;
  localparam syndrome_t  SYN_LOCAL_CLOSE = 8'h9F;

  typedef enum logic [2:0] {
    MTU_256  = 3'd0,
    MTU_512  = 3'd1,
    MTU_1024 = 3'd2,
    MTU_2048 = 3'd3,
    MTU_4096 = 3'd4
  } pmtu_e;

  // log2 of the smallest path MTU
  localparam int PMTU_SHIFT_BASE = 8;

  function automatic logic qpn_in_range(qpn_t qpn);
    return (qpn >= QPN_BASE) && (qpn < QPN_BASE + qpn_t'(NUM_QP));
  endfunction

  function automatic qp_idx_t qpn_to_idx(qpn_t qpn);
    qpn_t offset;
    offset = qpn - QPN_BASE;
    return offset[QP_IDX_W-1:0];
  endfunction

endpackage

`default_nettype wire

// File: qp_types_pkg.sv
`default_nettype none

package qp_types_pkg;

  // Local queue pairs held in the table
  localparam int NUM_QP   = 4;
  localparam int QP_IDX_W = $clog2(NUM_QP);

  typedef logic [23:0]         qpn_t;
  typedef logic [23:0]         psn_t;
  typedef logic [31:0]         rkey_t;
  typedef logic [31:0]         ip_addr_t;
  typedef logic [63:0]         vaddr_t;
  typedef logic [31:0]         dma_len_t;
  typedef logic [7:0]          syndrome_t;
  typedef logic [QP_IDX_W-1:0] qp_idx_t;

  typedef enum logic [2:0] {
    RESET    = 3'd0,
    INIT     = 3'd1,
    RTR      = 3'd2,
    RTS      = 3'd3,
    SQ_DRAIN = 3'd4,
    SQ_ERROR = 3'd5,
    ERROR    = 3'd6
  } qp_state_e;

  // Table write actions issued by the command FSM
  typedef enum logic [1:0] {
    OPEN      = 2'd0,
    SET_PSN   = 2'd1,
    SET_ERROR = 2'd2,
    SET_RESET = 2'd3
  } wr_op_e;

  typedef struct packed {
    ip_addr_t rem_ip_addr;
    qpn_t     rem_qpn;
    qpn_t     loc_qpn;
    psn_t     rem_psn;
    psn_t     loc_psn;
    vaddr_t   rem_addr;
    rkey_t    r_key;
  } qp_init_t;

  typedef struct packed {
    qp_state_e state;
    syndrome_t syndrome;
    ip_addr_t  rem_ip_addr;
    qpn_t      rem_qpn;
    qpn_t      loc_qpn;
    psn_t      rem_psn;
    psn_t      loc_psn;
    vaddr_t    rem_addr;
    rkey_t     r_key;
  } qp_context_t;

  // BTH and AETH fields of a received ACK
  typedef struct packed {
    logic [7:0] op_code;
    psn_t       psn;
    qpn_t       dest_qp;
    syndrome_t  syndrome;
  } rx_ack_t;

  typedef struct packed {
    dma_len_t dma_length;
    qpn_t     loc_qpn;
    psn_t     rem_psn;
  } dma_meta_t;

endpackage

`default_nettype wire
